// ==== common/icache_cfg.svh ====
// size constants of the instruction cache, included by the package, the RTL and the testbench
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// associativity
`define ICACHE_WAYS 4

// number of sets, each indexed by the bits above the line offset
`define ICACHE_SETS 16

// bytes per cache line, one refill moves a whole line
`define ICACHE_LINE_BYTES 16

// physical byte address width of a fetch
`define ICACHE_ADDR_WIDTH 16

// width of one fetched instruction word
`define ICACHE_FETCH_WIDTH 32

`endif

// ==== common/icache_pkg.sv ====
// shared types of the instruction cache, imported by the cache RTL and the testbench
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

  // address field widths, derived from the size macros
  localparam int unsigned OFF_W = $clog2(`ICACHE_LINE_BYTES);
  localparam int unsigned IDX_W = $clog2(`ICACHE_SETS);
  localparam int unsigned TAG_W = `ICACHE_ADDR_WIDTH - IDX_W - OFF_W;
  localparam int unsigned WAY_W = $clog2(`ICACHE_WAYS);

  typedef logic [`ICACHE_ADDR_WIDTH-1:0]     addr_t;
  typedef logic [TAG_W-1:0]                  tag_t;
  typedef logic [IDX_W-1:0]                  index_t;
  typedef logic [OFF_W-1:0]                  offset_t;
  typedef logic [8*`ICACHE_LINE_BYTES-1:0]   line_t;
  typedef logic [`ICACHE_FETCH_WIDTH-1:0]    word_t;
  typedef logic [WAY_W-1:0]                  way_idx_t;
  typedef logic [`ICACHE_WAYS-1:0]           way_mask_t;

  // controller FSM
  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} ctrl_state_e;

  // kind of packet on the return port
  typedef enum logic {FILL = 1'b0, INV = 1'b1} rtrn_type_e;

  // pick the fetch word at a byte offset, the low two offset bits are ignored
  function automatic word_t line_word(line_t line, offset_t off);
    int unsigned sel;
    sel = int'(off[OFF_W-1:2]);
    return line[sel*`ICACHE_FETCH_WIDTH +: `ICACHE_FETCH_WIDTH];
  endfunction

endpackage

`default_nettype wire

// ==== common/icache_array_if.sv ====
// connects the cache controller to the tag, valid and data arrays
`timescale 1ns/1ps
`default_nettype none

interface icache_array_if import icache_pkg::*; ();

  // lookup, result shows up one cycle later
  logic      lookup_en;
  index_t    lookup_idx;
  tag_t      cmp_tag;
  offset_t   word_off;

  // line write into the victim way
  logic      fill_en;
  index_t    fill_idx;
  line_t     fill_line;

  // valid clear of one set, all ways
  logic      clr_en;
  index_t    clr_idx;

  // results from the arrays
  logic      hit;
  word_t     hit_word;
  way_mask_t valid_mask;

  modport ctrl (
    output lookup_en, lookup_idx, cmp_tag, word_off,
    output fill_en, fill_idx, fill_line, clr_en, clr_idx,
    input  hit, hit_word, valid_mask
  );

  modport array (
    input  lookup_en, lookup_idx, cmp_tag, word_off,
    input  fill_en, fill_idx, fill_line, clr_en, clr_idx,
    output hit, hit_word, valid_mask
  );

endinterface

`default_nettype wire

// ==== icache/icache_arrays.sv ====
// tag, valid and data storage per way, with registered read, tag compare and word select
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_arrays import icache_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  way_idx_t victim_way_i,
  icache_array_if.array arr
);

  tag_t      tag_mem  [`ICACHE_SETS][`ICACHE_WAYS];
  line_t     data_mem [`ICACHE_SETS][`ICACHE_WAYS];
  way_mask_t valid_q  [`ICACHE_SETS];

  // registered readout of one set
  tag_t      tag_r  [`ICACHE_WAYS];
  line_t     line_r [`ICACHE_WAYS];
  way_mask_t valid_r;
  logic      lookup_q;

  way_mask_t hit_oh;

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  // valid bits are cleared by the flush walk after reset
  always_ff @(posedge clk_i) begin
    if (arr.clr_en) begin
      valid_q[arr.clr_idx] <= '0;
    end else if (arr.fill_en) begin
      valid_q[arr.fill_idx][victim_way_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (arr.fill_en) begin
      tag_mem[arr.fill_idx][victim_way_i]  <= arr.cmp_tag;
      data_mem[arr.fill_idx][victim_way_i] <= arr.fill_line;
    end
  end

  always_ff @(posedge clk_i) begin
    if (arr.lookup_en) begin
      valid_r <= valid_q[arr.lookup_idx];
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        tag_r[w]  <= tag_mem[arr.lookup_idx][w];
        line_r[w] <= data_mem[arr.lookup_idx][w];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lookup_q <= 1'b0;
    end else begin
      lookup_q <= arr.lookup_en;
    end
  end

  // victim choice looks at the set being filled right now
  assign arr.valid_mask = valid_q[arr.fill_idx];

  //////////////////////////////////////////////////////////////////////
  // tag compare and word select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      hit_oh[w] = valid_r[w] & (tag_r[w] == arr.cmp_tag);
    end
  end

  assign arr.hit = |hit_oh;

  // and-or mux, at most one way matches
  always_comb begin
    arr.hit_word = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (hit_oh[w]) begin
        arr.hit_word = arr.hit_word | line_word(line_r[w], arr.word_off);
      end
    end
  end

  // a line is never allocated twice in one set
  a_hit_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni) lookup_q |-> $onehot0(hit_oh)
  ) else $error("more than one way hit");

endmodule

`default_nettype wire

// ==== icache/icache_repl.sv ====
// picks the victim way of a refill from the lowest invalid way or from an 8-bit LFSR
`timescale 1ns/1ps
`default_nettype none

module icache_repl import icache_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  way_mask_t valid_mask_i,
  input  logic      fill_i,
  output way_idx_t  victim_way_o
);

  logic     all_valid;
  way_idx_t inv_way;
  logic [7:0] lfsr_q;

  assign all_valid = &valid_mask_i;

  // scan from the top so the lowest invalid way wins
  always_comb begin
    inv_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_mask_i[w]) begin
        inv_way = way_idx_t'(w);
      end
    end
  end

  assign victim_way_o = all_valid ? lfsr_q[WAY_W-1:0] : inv_way;

  // galois LFSR for x^8 + x^6 + x^5 + x^4 + 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'hff;
    end else if (fill_i && all_valid) begin
      lfsr_q <= (lfsr_q >> 1) ^ (lfsr_q[0] ? 8'hb8 : 8'h00);
    end
  end

endmodule

`default_nettype wire

// ==== icache/icache_ctrl.sv ====
// cache controller FSM that handles flush, lookup, line refill and set invalidation
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  input  logic       fetch_req_i,
  input  addr_t      fetch_addr_i,
  output logic       fetch_ready_o,
  output logic       fetch_valid_o,
  output word_t      fetch_data_o,
  output logic       mem_req_o,
  output addr_t      mem_addr_o,
  input  logic       mem_ack_i,
  input  logic       mem_rtrn_vld_i,
  input  rtrn_type_e mem_rtrn_type_i,
  input  line_t      mem_rtrn_data_i,
  input  index_t     mem_rtrn_idx_i,
  output logic       miss_o,
  output logic       fill_o,
  icache_array_if.ctrl arr
);

  ctrl_state_e state_d, state_q;
  logic        flush_d, flush_q;
  logic        inv_en;
  logic        fill_rtrn;
  logic        accept;
  logic        flush_done;
  index_t      flush_cnt_q;
  addr_t       addr_q;
  // fields of the accepted request
  tag_t        tag_q;
  index_t      idx_q;
  offset_t     off_q;

  assign {tag_q, idx_q, off_q} = addr_q;

  assign accept     = fetch_req_i & fetch_ready_o;
  assign inv_en     = mem_rtrn_vld_i & (mem_rtrn_type_i == INV);
  assign fill_rtrn  = mem_rtrn_vld_i & (mem_rtrn_type_i == FILL);
  assign flush_done = (flush_cnt_q == index_t'(`ICACHE_SETS - 1));

  // refill always asks for the whole line
  assign mem_addr_o = {tag_q, idx_q, {OFF_W{1'b0}}};

  //////////////////////////////////////////////////////////////////////
  // main FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    flush_d       = flush_q | flush_i;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;
    fill_o        = 1'b0;
    arr.lookup_en = 1'b0;
    unique case (state_q)
      FLUSH: begin
        if (flush_done) begin
          state_d = IDLE;
          flush_d = 1'b0;
        end
      end
      IDLE: begin
        if (flush_d) begin
          state_d = FLUSH;
        // a busy return port carries an inval so no lookup starts
        end else if (!mem_rtrn_vld_i) begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            arr.lookup_en = 1'b1;
            state_d       = READ;
          end
        end
      end
      READ: begin
        if (arr.hit) begin
          fetch_valid_o = 1'b1;
          state_d       = flush_d ? FLUSH : IDLE;
          // back to back hits
          if (!flush_d && !mem_rtrn_vld_i) begin
            fetch_ready_o = 1'b1;
            if (fetch_req_i) begin
              arr.lookup_en = 1'b1;
              state_d       = READ;
            end
          end
        end else begin
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = 1'b1;
            state_d = MISS;
          end
        end
      end
      MISS: begin
        // fill and forward in the same cycle
        if (fill_rtrn) begin
          fetch_valid_o = 1'b1;
          fill_o        = 1'b1;
          state_d       = flush_d ? FLUSH : IDLE;
        end
      end
      default: state_d = FLUSH;
    endcase
  end

  // array side
  assign arr.lookup_idx = accept ? fetch_addr_i[OFF_W +: IDX_W] : idx_q;
  assign arr.cmp_tag    = tag_q;
  assign arr.word_off   = off_q;
  assign arr.fill_en    = fill_o;
  assign arr.fill_idx   = idx_q;
  assign arr.fill_line  = mem_rtrn_data_i;
  // flush walk has priority over a returning inval
  assign arr.clr_en     = (state_q == FLUSH) | inv_en;
  assign arr.clr_idx    = (state_q == FLUSH) ? flush_cnt_q : mem_rtrn_idx_i;

  // word straight from the return port while a miss is open
  assign fetch_data_o = (state_q == MISS) ? line_word(mem_rtrn_data_i, off_q) : arr.hit_word;

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      flush_q <= flush_d;
      if (state_q == FLUSH) begin
        flush_cnt_q <= flush_done ? '0 : flush_cnt_q + 1'b1;
      end
    end
  end

  // request address
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
  end

  // refill request and its line address hold until the acknowledge
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o)
  ) else $error("refill request dropped or changed before its acknowledge");

  // fills are only sent for an acknowledged refill
  a_fill_in_miss : assert property (
    @(posedge clk_i) disable iff (!rst_ni) fill_rtrn |-> (state_q == MISS)
  ) else $error("fill return outside of a miss");

endmodule

`default_nettype wire

// ==== icache/icache_top.sv ====
// instruction cache top level, plain fetch, refill and return ports for the integrating core
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  // fetch port
  input  logic       fetch_req_i,
  input  addr_t      fetch_addr_i,
  output logic       fetch_ready_o,
  output logic       fetch_valid_o,
  output word_t      fetch_data_o,
  // refill request
  output logic       mem_req_o,
  output addr_t      mem_addr_o,
  input  logic       mem_ack_i,
  // return port, always consumed
  input  logic       mem_rtrn_vld_i,
  input  rtrn_type_e mem_rtrn_type_i,
  input  line_t      mem_rtrn_data_i,
  input  index_t     mem_rtrn_idx_i,
  // miss pulse for performance counting
  output logic       miss_o
);

  logic     fill;
  way_idx_t victim_way;

  icache_array_if arr_if ();

  icache_ctrl i_icache_ctrl (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .flush_i         ( flush_i         ),
    .fetch_req_i     ( fetch_req_i     ),
    .fetch_addr_i    ( fetch_addr_i    ),
    .fetch_ready_o   ( fetch_ready_o   ),
    .fetch_valid_o   ( fetch_valid_o   ),
    .fetch_data_o    ( fetch_data_o    ),
    .mem_req_o       ( mem_req_o       ),
    .mem_addr_o      ( mem_addr_o      ),
    .mem_ack_i       ( mem_ack_i       ),
    .mem_rtrn_vld_i  ( mem_rtrn_vld_i  ),
    .mem_rtrn_type_i ( mem_rtrn_type_i ),
    .mem_rtrn_data_i ( mem_rtrn_data_i ),
    .mem_rtrn_idx_i  ( mem_rtrn_idx_i  ),
    .miss_o          ( miss_o          ),
    .fill_o          ( fill            ),
    .arr             ( arr_if.ctrl     )
  );

  icache_arrays i_icache_arrays (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .victim_way_i ( victim_way   ),
    .arr          ( arr_if.array )
  );

  icache_repl i_icache_repl (
    .clk_i        ( clk_i              ),
    .rst_ni       ( rst_ni             ),
    .valid_mask_i ( arr_if.valid_mask  ),
    .fill_i       ( fill               ),
    .victim_way_o ( victim_way         )
  );

endmodule

`default_nettype wire

// ==== testbench/icache_checker.sv ====
// watches the cache ports, keeps a model of resident lines and compares every response
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_checker import icache_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       flush_i,
  input logic       fetch_req_i,
  input addr_t      fetch_addr_i,
  input logic       fetch_ready_i,
  input logic       fetch_valid_i,
  input word_t      fetch_data_i,
  input logic       mem_req_i,
  input addr_t      mem_addr_i,
  input logic       mem_ack_i,
  input logic       mem_rtrn_vld_i,
  input rtrn_type_e mem_rtrn_type_i,
  input index_t     mem_rtrn_idx_i,
  input logic       miss_i,
  input logic [15:0] ver_i [32]
);

  int unsigned err_cnt = 0;
  int unsigned chk_cnt = 0;
  int unsigned miss_cnt = 0;
  // outstanding fetches in order of acceptance
  addr_t       q_addr [$];
  int unsigned q_cyc  [$];
  bit          q_hit  [$];
  bit          q_miss [$];
  bit          refilled = 1'b0;
  // last line filled per set, -1 once the set was cleared
  int          last_fill [`ICACHE_SETS];
  bit          must_miss [32];
  int unsigned cycle = 0;
  int unsigned ready_low = 0;
  bit          seen_req = 1'b0;
  logic [4:0]  lid;

  // test lines use tag bits 10:8 and index bits 5:4
  function automatic logic [4:0] line_id(input addr_t a);
    return {a[10:8], a[5:4]};
  endfunction

  function automatic word_t expected_word(input addr_t a);
    return {ver_i[line_id(a)] ^ 16'h9e37, a & 16'hfffc};
  endfunction

  task automatic flag_error(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  // everything misses after reset, the flush walk starts empty
  initial begin
    foreach (last_fill[s]) last_fill[s] = -1;
    foreach (must_miss[l]) must_miss[l] = 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // per cycle comparison
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycle++;
      if (!seen_req && (fetch_valid_i || mem_req_i || miss_i)) begin
        flag_error("control output high before the first fetch request");
      end
      chk_cnt++;
      if (miss_i != (mem_req_i && mem_ack_i)) begin
        flag_error("miss_o does not line up with an acknowledged refill");
      end
      miss_cnt += int'(miss_i);
      // ready stays low for the whole flush walk
      if (ready_low > 0) begin
        if (fetch_ready_i) flag_error("fetch_ready_o high during a flush");
        ready_low--;
      end
      if (flush_i) begin
        ready_low = `ICACHE_SETS;
        foreach (last_fill[s]) last_fill[s] = -1;
        foreach (must_miss[l]) must_miss[l] = 1'b1;
      end
      if (mem_rtrn_vld_i && mem_rtrn_type_i == INV) begin
        for (int l = 0; l < 32; l++) begin
          if (index_t'(l % 4) == mem_rtrn_idx_i) must_miss[l] = 1'b1;
        end
        last_fill[mem_rtrn_idx_i] = -1;
      end
      if (mem_req_i && mem_ack_i) begin
        if (q_addr.size() == 0) begin
          flag_error("refill request with no fetch outstanding");
        end else begin
          chk_cnt++;
          if (mem_addr_i != {q_addr[0][15:4], 4'h0}) begin
            flag_error($sformatf("Fail mem_addr_o: got %h, expected %h",
                                 mem_addr_i, {q_addr[0][15:4], 4'h0}));
          end
          if (q_hit[0]) flag_error("refill issued for a line that was just filled");
          refilled = 1'b1;
        end
      end
      if (mem_rtrn_vld_i && mem_rtrn_type_i == FILL && q_addr.size() != 0) begin
        lid = line_id(q_addr[0]);
        last_fill[q_addr[0][7:4]] = int'(lid);
        must_miss[lid] = 1'b0;
      end
      if (fetch_valid_i) begin
        if (q_addr.size() == 0) begin
          flag_error("fetch_valid_o with no fetch outstanding");
        end else begin
          chk_cnt++;
          if (fetch_data_i != expected_word(q_addr[0])) begin
            flag_error($sformatf("Fail fetch_data_o: got %h, expected %h",
                                 fetch_data_i, expected_word(q_addr[0])));
          end
          if (q_hit[0] && cycle != q_cyc[0] + 1) begin
            flag_error("hit did not complete one cycle after acceptance");
          end
          if (q_miss[0] && !refilled) begin
            flag_error("fetch after invalidation or flush completed without refill");
          end
          void'(q_addr.pop_front());
          void'(q_cyc.pop_front());
          void'(q_hit.pop_front());
          void'(q_miss.pop_front());
          refilled = 1'b0;
        end
      end
      if (fetch_req_i && fetch_ready_i) begin
        seen_req = 1'b1;
        lid = line_id(fetch_addr_i);
        q_addr.push_back(fetch_addr_i);
        q_cyc.push_back(cycle);
        q_hit.push_back(last_fill[fetch_addr_i[7:4]] == int'(lid));
        q_miss.push_back(must_miss[lid]);
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_icache.sv ====
// testbench top for the instruction cache that runs random fetches against a versioned memory model
`timescale 1ns/1ps
`default_nettype none

module tb_icache import icache_pkg::*; ();

  localparam int unsigned N_REQ   = 400;
  localparam int unsigned N_LINES = 32;
  localparam int unsigned TIMEOUT = N_REQ * 12 + 200;

  logic       clk_i;
  logic       rst_ni;
  logic       flush_i;
  logic       fetch_req_i;
  addr_t      fetch_addr_i;
  logic       fetch_ready_o;
  logic       fetch_valid_o;
  word_t      fetch_data_o;
  logic       mem_req_o;
  addr_t      mem_addr_o;
  logic       mem_ack_i;
  logic       mem_rtrn_vld_i;
  rtrn_type_e mem_rtrn_type_i;
  line_t      mem_rtrn_data_i;
  index_t     mem_rtrn_idx_i;
  logic       miss_o;

  // version per test line that each INV bumps
  logic [15:0] line_ver [N_LINES];
  logic [31:0] rng;
  int unsigned cycles;

  icache_top i_icache_top (.*);

  icache_checker i_checker (
    .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush_i),
    .fetch_req_i (fetch_req_i), .fetch_addr_i (fetch_addr_i),
    .fetch_ready_i (fetch_ready_o), .fetch_valid_i (fetch_valid_o),
    .fetch_data_i (fetch_data_o), .mem_req_i (mem_req_o), .mem_addr_i (mem_addr_o),
    .mem_ack_i (mem_ack_i), .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .mem_rtrn_type_i (mem_rtrn_type_i), .mem_rtrn_idx_i (mem_rtrn_idx_i),
    .miss_i (miss_o), .ver_i (line_ver)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 8 tags on 4 sets so that sets overflow and ways get replaced
  function automatic addr_t line_addr(input logic [4:0] l);
    return {5'b0, l[4:2], 2'b0, l[1:0], 4'h0};
  endfunction

  function automatic line_t mem_line(input addr_t base, input logic [15:0] ver);
    line_t ln;
    for (int w = 0; w < 4; w++) begin
      ln[w*32 +: 32] = {ver ^ 16'h9e37, base + addr_t'(4 * w)};
    end
    return ln;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks that drive on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic fetch_word(input logic [4:0] l, input logic [1:0] w);
    @(negedge clk_i);
    fetch_req_i  = 1'b1;
    fetch_addr_i = line_addr(l) | addr_t'({w, 2'b00});
    while (!fetch_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    fetch_req_i = 1'b0;
    if (!fetch_valid_o) begin
      while (!mem_req_o) @(negedge clk_i);
      // ack after 0 to 3 cycles
      rng = xorshift(rng);
      repeat (rng[1:0]) @(negedge clk_i);
      mem_ack_i = 1'b1;
      @(negedge clk_i);
      mem_ack_i = 1'b0;
      // fill 1 to 4 cycles after the ack
      rng = xorshift(rng);
      repeat (rng[1:0]) @(negedge clk_i);
      mem_rtrn_vld_i  = 1'b1;
      mem_rtrn_type_i = FILL;
      mem_rtrn_data_i = mem_line(line_addr(l), line_ver[l]);
      mem_rtrn_idx_i  = index_t'(l[1:0]);
      @(negedge clk_i);
      mem_rtrn_vld_i = 1'b0;
    end
  endtask

  task automatic send_inval(input logic [4:0] l);
    @(negedge clk_i);
    line_ver[l]     = line_ver[l] + 16'd1;
    mem_rtrn_vld_i  = 1'b1;
    mem_rtrn_type_i = INV;
    mem_rtrn_idx_i  = index_t'(l[1:0]);
    @(negedge clk_i);
    mem_rtrn_vld_i = 1'b0;
  endtask

  task automatic pulse_flush();
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // run limit
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles, the fetch sequence did not finish", cycles);
    $display("Verification failed");
    $finish;
  end

  initial begin
    logic [4:0] l;
    rst_ni          = 1'b0;
    flush_i         = 1'b0;
    fetch_req_i     = 1'b0;
    fetch_addr_i    = '0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_type_i = FILL;
    mem_rtrn_data_i = '0;
    mem_rtrn_idx_i  = '0;
    foreach (line_ver[i]) line_ver[i] = '0;
    rng = 32'hfb46;
    l   = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int unsigned n = 0; n < N_REQ; n++) begin
      rng = xorshift(rng);
      // idle gaps now and then carry an INV or a flush
      if (rng[7:4] == 4'h0) begin
        send_inval(rng[12:8]);
      end else if (rng[13:8] == 6'h0) begin
        pulse_flush();
      end
      rng = xorshift(rng);
      // often the same line again to see the fill hit
      if (rng[9:8] != 2'b00) l = rng[4:0];
      fetch_word(l, rng[6:5]);
    end
    repeat (4) @(negedge clk_i);
    $display("checks %0d, errors %0d, misses %0d",
             i_checker.chk_cnt, i_checker.err_cnt, i_checker.miss_cnt);
    if (i_checker.err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/icache_pkg.sv
common/icache_array_if.sv
icache/icache_arrays.sv
icache/icache_repl.sv
icache/icache_ctrl.sv
icache/icache_top.sv
testbench/icache_checker.sv
testbench/tb_icache.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_icache
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the simulation prints the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf $(OBJ_DIR)
